// ==== common/decode_pkg.sv ====
package decode_pkg;

  localparam int xlen = 32;
  localparam int opcode_w = 6;
  localparam int greg_id_w = 4;
  localparam int preg_id_w = 2;
  localparam int alu_op_w = 4;

  // memory and predicate ops
  localparam logic [opcode_w-1:0] op_ld = 6'h23;
  localparam logic [opcode_w-1:0] op_st = 6'h24;
  localparam logic [opcode_w-1:0] op_ldi = 6'h25;
  localparam logic [opcode_w-1:0] op_rtop = 6'h26;
  localparam logic [opcode_w-1:0] op_andp = 6'h27;
  localparam logic [opcode_w-1:0] op_orp = 6'h28;
  localparam logic [opcode_w-1:0] op_xorp = 6'h29;
  localparam logic [opcode_w-1:0] op_notp = 6'h2a;
  localparam logic [opcode_w-1:0] op_isneg = 6'h2b;
  localparam logic [opcode_w-1:0] op_iszero = 6'h2c;

  localparam logic [opcode_w-1:0] op_neg = 6'h05;
  localparam logic [opcode_w-1:0] op_not = 6'h06;
  localparam logic [opcode_w-1:0] op_and = 6'h07;
  localparam logic [opcode_w-1:0] op_or = 6'h08;
  localparam logic [opcode_w-1:0] op_xor = 6'h09;
  localparam logic [opcode_w-1:0] op_add = 6'h0a;
  localparam logic [opcode_w-1:0] op_sub = 6'h0b;
  localparam logic [opcode_w-1:0] op_mul = 6'h0c;
  localparam logic [opcode_w-1:0] op_div = 6'h0d;
  localparam logic [opcode_w-1:0] op_mod = 6'h0e;
  localparam logic [opcode_w-1:0] op_shl = 6'h0f;
  localparam logic [opcode_w-1:0] op_shr = 6'h10;

  localparam logic [opcode_w-1:0] op_andi = 6'h11;
  localparam logic [opcode_w-1:0] op_ori = 6'h12;
  localparam logic [opcode_w-1:0] op_xori = 6'h13;
  localparam logic [opcode_w-1:0] op_addi = 6'h14;
  localparam logic [opcode_w-1:0] op_subi = 6'h15;
  localparam logic [opcode_w-1:0] op_muli = 6'h16;
  localparam logic [opcode_w-1:0] op_divi = 6'h17;
  localparam logic [opcode_w-1:0] op_modi = 6'h18;
  localparam logic [opcode_w-1:0] op_shli = 6'h19;
  localparam logic [opcode_w-1:0] op_shri = 6'h1a;

  localparam logic [opcode_w-1:0] op_jali = 6'h1b;
  localparam logic [opcode_w-1:0] op_jalr = 6'h1c;
  localparam logic [opcode_w-1:0] op_jmpi = 6'h1d;
  localparam logic [opcode_w-1:0] op_jmpr = 6'h1e;

  localparam logic [alu_op_w-1:0] alu_add = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sub = 4'd2;
  localparam logic [alu_op_w-1:0] alu_mul = 4'd3;
  localparam logic [alu_op_w-1:0] alu_div = 4'd4;
  localparam logic [alu_op_w-1:0] alu_mod = 4'd5;
  localparam logic [alu_op_w-1:0] alu_shl = 4'd6;
  localparam logic [alu_op_w-1:0] alu_shr = 4'd7;
  localparam logic [alu_op_w-1:0] alu_and = 4'd8;
  localparam logic [alu_op_w-1:0] alu_or = 4'd9;
  localparam logic [alu_op_w-1:0] alu_xor = 4'd10;
  localparam logic [alu_op_w-1:0] alu_neg = 4'd11;
  localparam logic [alu_op_w-1:0] alu_not = 4'd12;
  localparam logic [alu_op_w-1:0] alu_ldi = 4'd13;
  localparam logic [alu_op_w-1:0] alu_link = 4'd14;

  // predicate unit reuses the low codes
  localparam logic [alu_op_w-1:0] alu_andp = 4'd1;
  localparam logic [alu_op_w-1:0] alu_orp = 4'd2;
  localparam logic [alu_op_w-1:0] alu_xorp = 4'd3;
  localparam logic [alu_op_w-1:0] alu_notp = 4'd4;
  localparam logic [alu_op_w-1:0] alu_rtop = 4'd5;
  localparam logic [alu_op_w-1:0] alu_isneg = 4'd6;
  localparam logic [alu_op_w-1:0] alu_iszero = 4'd7;

  localparam logic [1:0] sext_none = 2'd0;
  localparam logic [1:0] sext_15 = 2'd1;
  localparam logic [1:0] sext_23 = 2'd2;
  localparam logic [1:0] sext_19 = 2'd3;

  typedef struct packed {
    logic pset;
    logic [preg_id_w-1:0] pid;
    logic [opcode_w-1:0] opcode;
    logic [greg_id_w-1:0] rz;
    logic [greg_id_w-1:0] ry;
    logic [greg_id_w-1:0] rx;
    logic [10:0] unused;
  } inst_reg_t;

  typedef struct packed {
    logic pset;
    logic [preg_id_w-1:0] pid;
    logic [opcode_w-1:0] opcode;
    logic [22:0] imm;
  } inst_imm_t;

  typedef union packed {
    inst_reg_t reg_view;
    inst_imm_t imm_view;
  } inst_t;

endpackage

// ==== design/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder import decode_pkg::*; (
  input  logic [opcode_w-1:0] opcode,
  output logic reg_id_sel,
  output logic [1:0] sext_sel,
  output logic is_jump,
  output logic jmp_reg,
  output logic pf_i,
  output logic [alu_op_w-1:0] alu_op,
  output logic src2_imm,
  output logic link,
  output logic mem_r,
  output logic mem_w,
  output logic reg_mem,
  output logic wb_p,
  output logic wb_r
);

  always_comb
  begin
    reg_id_sel = 1'b0;
    sext_sel = sext_none;
    is_jump = 1'b0;
    jmp_reg = 1'b0;
    pf_i = 1'b0;
    alu_op = '0;
    src2_imm = 1'b0;
    link = 1'b0;
    mem_r = 1'b0;
    mem_w = 1'b0;
    reg_mem = 1'b0;
    wb_p = 1'b0;
    wb_r = 1'b0;

    // group controls
    case (opcode)
      op_ld:
      begin
        sext_sel = sext_15;
        pf_i = 1'b1;
        src2_imm = 1'b1;
        mem_r = 1'b1;
        reg_mem = 1'b1; // wb from memory
        wb_r = 1'b1;
      end
      op_st:
      begin
        reg_id_sel = 1'b1; // store data lives in rz
        sext_sel = sext_15;
        pf_i = 1'b1;
        src2_imm = 1'b1;
        mem_w = 1'b1;
      end
      op_andp, op_orp, op_xorp, op_notp, op_rtop, op_isneg, op_iszero:
        wb_p = 1'b1;
      op_ldi:
      begin
        sext_sel = sext_19;
        pf_i = 1'b1;
        src2_imm = 1'b1;
        wb_r = 1'b1;
      end
      op_andi, op_ori, op_xori, op_addi, op_subi,
      op_muli, op_divi, op_modi, op_shli, op_shri:
      begin
        sext_sel = sext_15;
        pf_i = 1'b1;
        src2_imm = 1'b1;
        wb_r = 1'b1;
      end
      op_neg, op_not, op_and, op_or, op_xor, op_add,
      op_sub, op_mul, op_div, op_mod, op_shl, op_shr:
      begin
        pf_i = 1'b1;
        wb_r = 1'b1;
      end
      op_jmpi:
      begin
        is_jump = 1'b1;
        sext_sel = sext_23;
      end
      op_jmpr:
      begin
        is_jump = 1'b1;
        jmp_reg = 1'b1;
        reg_id_sel = 1'b1; // target register in rz
      end
      op_jali, op_jalr:
      begin
        is_jump = 1'b1;
        jmp_reg = (opcode == op_jalr);
        sext_sel = (opcode == op_jali) ? sext_19 : sext_none;
        pf_i = 1'b1;
        link = 1'b1;
        wb_r = 1'b1;
      end
      default: ; // nop, fp and unused opcodes
    endcase

    // alu operation
    case (opcode)
      op_ld, op_st, op_add, op_addi: alu_op = alu_add;
      op_sub, op_subi: alu_op = alu_sub;
      op_mul, op_muli: alu_op = alu_mul;
      op_div, op_divi: alu_op = alu_div;
      op_mod, op_modi: alu_op = alu_mod;
      op_shl, op_shli: alu_op = alu_shl;
      op_shr, op_shri: alu_op = alu_shr;
      op_and, op_andi: alu_op = alu_and;
      op_or, op_ori: alu_op = alu_or;
      op_xor, op_xori: alu_op = alu_xor;
      op_neg: alu_op = alu_neg;
      op_not: alu_op = alu_not;
      op_ldi: alu_op = alu_ldi;
      op_jali, op_jalr: alu_op = alu_link;
      op_andp: alu_op = alu_andp;
      op_orp: alu_op = alu_orp;
      op_xorp: alu_op = alu_xorp;
      op_notp: alu_op = alu_notp;
      op_rtop: alu_op = alu_rtop;
      op_isneg: alu_op = alu_isneg;
      op_iszero: alu_op = alu_iszero;
      default: ;
    endcase
  end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; #(
  parameter int gregs = 16,
  parameter int pregs = 4
) (
  input  logic clk,
  input  logic rst,
  input  inst_t inst,
  input  logic [xlen-1:0] pc_n,
  input  logic p_we,
  input  logic [$clog2(pregs)-1:0] p_wid,
  input  logic p_wdata,
  input  logic r_we,
  input  logic [$clog2(gregs)-1:0] r_wid,
  input  logic [xlen-1:0] r_wdata,
  output logic [xlen-1:0] rx,
  output logic [xlen-1:0] ry,
  output logic px,
  output logic py,
  output logic pval,
  output logic [greg_id_w-1:0] z_id,
  output logic [greg_id_w-1:0] x_id,
  output logic [greg_id_w-1:0] y_id,
  output logic [xlen-1:0] imm_s,
  output logic [xlen-1:0] jmp_target,
  output logic is_jump,
  output logic jmp_reg,
  output logic pf_i,
  output logic [alu_op_w-1:0] alu_op,
  output logic src2_imm,
  output logic link,
  output logic mem_r,
  output logic mem_w,
  output logic reg_mem,
  output logic wb_p,
  output logic wb_r
);

  localparam int greg_aw = $clog2(gregs);
  localparam int preg_aw = $clog2(pregs);

  logic reg_id_sel;
  logic [1:0] sext_sel;

  control_decoder control_decoder_inst (
    .opcode(inst.reg_view.opcode),
    .reg_id_sel(reg_id_sel),
    .sext_sel(sext_sel),
    .is_jump(is_jump),
    .jmp_reg(jmp_reg),
    .pf_i(pf_i),
    .alu_op(alu_op),
    .src2_imm(src2_imm),
    .link(link),
    .mem_r(mem_r),
    .mem_w(mem_w),
    .reg_mem(reg_mem),
    .wb_p(wb_p),
    .wb_r(wb_r)
  );

  assign z_id = inst.reg_view.rz;
  assign y_id = inst.reg_view.ry;
  // st and jmpr read the register named in rz
  assign x_id = reg_id_sel ? inst.reg_view.rz : inst.reg_view.rx;

  greg_file #(
    .gregs(gregs)
  ) greg_file_inst (
    .clk(clk),
    .rst(rst),
    .rx_id(x_id[greg_aw-1:0]),
    .ry_id(y_id[greg_aw-1:0]),
    .we(r_we),
    .wid(r_wid),
    .wdata(r_wdata),
    .rx(rx),
    .ry(ry)
  );

  preg_file #(
    .pregs(pregs)
  ) preg_file_inst (
    .clk(clk),
    .rst(rst),
    .rx_id(x_id[preg_aw-1:0]), // low bits pick the predicate
    .ry_id(y_id[preg_aw-1:0]),
    .pset(inst.reg_view.pset),
    .pid(inst.reg_view.pid[preg_aw-1:0]),
    .we(p_we),
    .wid(p_wid),
    .wdata(p_wdata),
    .px(px),
    .py(py),
    .pval(pval)
  );

  imm_target_gen imm_target_gen_inst (
    .sext_sel(sext_sel),
    .field(inst.imm_view.imm),
    .pc_n(pc_n),
    .imm_s(imm_s),
    .jmp_target(jmp_target)
  );

endmodule

// ==== design/imm_target_gen.sv ====
`timescale 1ns/1ps

module imm_target_gen import decode_pkg::*; (
  input  logic [1:0] sext_sel,
  input  logic [22:0] field,
  input  logic [xlen-1:0] pc_n,
  output logic [xlen-1:0] imm_s,
  output logic [xlen-1:0] jmp_target
);

  always_comb
  begin
    case (sext_sel)
      sext_15: imm_s = {{(xlen-15){field[14]}}, field[14:0]};
      sext_19: imm_s = {{(xlen-19){field[18]}}, field[18:0]};
      sext_23: imm_s = {{(xlen-23){field[22]}}, field[22:0]};
      default: imm_s = '0;
    endcase
  end

  // wraps at 2^32
  assign jmp_target = pc_n + imm_s;

endmodule

// ==== files.f ====
common/decode_pkg.sv
design/control_decoder.sv
regfile/greg_file.sv
regfile/preg_file.sv
design/imm_target_gen.sv
design/decode_stage.sv
verif/decode_stage_props.sv
verif/decode_stage_tb.sv

// ==== regfile/greg_file.sv ====
`timescale 1ns/1ps

module greg_file import decode_pkg::*; #(
  parameter int gregs = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic [$clog2(gregs)-1:0] rx_id,
  input  logic [$clog2(gregs)-1:0] ry_id,
  input  logic we,
  input  logic [$clog2(gregs)-1:0] wid,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rx,
  output logic [xlen-1:0] ry
);

  logic [xlen-1:0] regs [gregs];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < gregs; i++)
        regs[i] <= xlen'(i); // each reg starts at its index
    end
    else if (we)
    begin
      regs[wid] <= wdata;
    end
  end

  assign rx = regs[rx_id];
  assign ry = regs[ry_id];

endmodule

// ==== regfile/preg_file.sv ====
`timescale 1ns/1ps

module preg_file #(
  parameter int pregs = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic [$clog2(pregs)-1:0] rx_id,
  input  logic [$clog2(pregs)-1:0] ry_id,
  input  logic pset,
  input  logic [$clog2(pregs)-1:0] pid,
  input  logic we,
  input  logic [$clog2(pregs)-1:0] wid,
  input  logic wdata,
  output logic px,
  output logic py,
  output logic pval
);

  // p0 and p1 start true, the rest false
  localparam logic [pregs-1:0] reset_val = pregs'(2'b11);

  logic [pregs-1:0] pbits;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pbits <= reset_val;
    end
    else if (we)
    begin
      pbits[wid] <= wdata;
    end
  end

  assign px = pbits[rx_id];
  assign py = pbits[ry_id];
  assign pval = pset ? pbits[pid] : 1'b1; // unguarded always runs

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module decode_stage_tb \
  -o decode_stage_sim \
  && ./obj_dir/decode_stage_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verif/decode_stage_props.sv ====
`timescale 1ns/1ps

module decode_stage_props (
  input logic clk,
  input logic rst,
  input logic pset,
  input logic pval,
  input logic is_jump,
  input logic mem_r,
  input logic mem_w
);

  mem_rw_excl: assert property (@(posedge clk) disable iff (rst) !(mem_r && mem_w))
    else $error("mem_r and mem_w high together");

  unguarded_runs: assert property (@(posedge clk) disable iff (rst) !pset |-> pval)
    else $error("pval low on an unguarded instruction");

  jump_no_store: assert property (@(posedge clk) disable iff (rst) is_jump |-> !mem_w)
    else $error("mem_w high on a jump");

endmodule

bind decode_stage decode_stage_props decode_stage_props_inst (
  .clk(clk),
  .rst(rst),
  .pset(inst.reg_view.pset),
  .pval(pval),
  .is_jump(is_jump),
  .mem_r(mem_r),
  .mem_w(mem_w)
);

// ==== verif/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

  localparam int max_cycles = 2000; // tests take about 300 cycles
  localparam logic [alu_op_w-1:0] arith_alu [10] = '{alu_and, alu_or, alu_xor, alu_add,
    alu_sub, alu_mul, alu_div, alu_mod, alu_shl, alu_shr};

  bit clk;
  logic rst;
  inst_t inst;
  logic [xlen-1:0] pc_n;
  logic p_we;
  logic [1:0] p_wid;
  logic p_wdata;
  logic r_we;
  logic [3:0] r_wid;
  logic [xlen-1:0] r_wdata;
  logic [xlen-1:0] rx, ry, imm_s, jmp_target;
  logic px, py, pval;
  logic [greg_id_w-1:0] z_id, x_id, y_id;
  logic is_jump, jmp_reg, pf_i, src2_imm, link, mem_r, mem_w, reg_mem, wb_p, wb_r;
  logic [alu_op_w-1:0] alu_op;

  logic [xlen-1:0] gmodel [16];
  logic pmodel [4];
  logic [alu_op_w-1:0] exp_alu [64];
  logic [7:0] exp_flags [64]; // src2_imm mem_r mem_w wb_p wb_r is_jump jmp_reg link
  integer seed;
  int cycles;

  decode_stage decode_stage_inst (.*);

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("timeout: tests did not finish");
      $display("TESTS FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic report_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic check_word(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                            input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_alu(input logic [alu_op_w-1:0] got, input logic [alu_op_w-1:0] exp,
                           input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_id(input logic [greg_id_w-1:0] got, input logic [greg_id_w-1:0] exp,
                          input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  function automatic inst_t reg_inst(input logic [5:0] op, input logic [3:0] z,
                                     input logic [3:0] y, input logic [3:0] x);
    inst_t i;
    i = '0;
    i.reg_view.opcode = op;
    i.reg_view.rz = z;
    i.reg_view.ry = y;
    i.reg_view.rx = x;
    return i;
  endfunction

  function automatic inst_t imm_inst(input logic [5:0] op, input logic [22:0] imm);
    inst_t i;
    i = '0;
    i.imm_view.opcode = op;
    i.imm_view.imm = imm;
    return i;
  endfunction

  // reference sign extension of the low w bits
  function automatic logic [xlen-1:0] sext_ref(input logic [22:0] f, input int w);
    logic [xlen-1:0] v;
    v = {9'b0, f} & ((xlen'(1) << w) - 1);
    if (((v >> (w - 1)) & 1) != 0)
      v = v - (xlen'(1) << w);
    return v;
  endfunction

  task automatic set_entry(input logic [5:0] op, input logic [3:0] alu, input logic [7:0] flags);
    exp_alu[op] = alu;
    exp_flags[op] = flags;
  endtask

  task automatic build_table;
    for (int op = 0; op < 64; op++)
      set_entry(6'(op), '0, 8'b0); // fp and unused stay nop
    set_entry(op_ld, alu_add, 8'b1100_1000);
    set_entry(op_st, alu_add, 8'b1010_0000);
    set_entry(op_ldi, alu_ldi, 8'b1000_1000);
    for (int k = 0; k < 10; k++)
    begin
      set_entry(opcode_w'(int'(op_andi) + k), arith_alu[k], 8'b1000_1000);
      set_entry(opcode_w'(int'(op_and) + k), arith_alu[k], 8'b0000_1000);
    end
    set_entry(op_neg, alu_neg, 8'b0000_1000);
    set_entry(op_not, alu_not, 8'b0000_1000);
    set_entry(op_andp, alu_andp, 8'b0001_0000);
    set_entry(op_orp, alu_orp, 8'b0001_0000);
    set_entry(op_xorp, alu_xorp, 8'b0001_0000);
    set_entry(op_notp, alu_notp, 8'b0001_0000);
    set_entry(op_rtop, alu_rtop, 8'b0001_0000);
    set_entry(op_isneg, alu_isneg, 8'b0001_0000);
    set_entry(op_iszero, alu_iszero, 8'b0001_0000);
    set_entry(op_jmpi, '0, 8'b0000_0100);
    set_entry(op_jmpr, '0, 8'b0000_0110);
    set_entry(op_jali, alu_link, 8'b0000_1101);
    set_entry(op_jalr, alu_link, 8'b0000_1111);
  endtask

  task automatic apply_inst(input inst_t i);
    @(negedge clk);
    inst = i;
    #1;
  endtask

  task automatic check_table(input logic [5:0] op);
    string s;
    s = $sformatf("op %h", op);
    check_alu(alu_op, exp_alu[op], {s, " alu_op"});
    check_bit(src2_imm, exp_flags[op][7], {s, " src2_imm"});
    check_bit(mem_r, exp_flags[op][6], {s, " mem_r"});
    check_bit(reg_mem, exp_flags[op][6], {s, " reg_mem"}); // loads write back from memory
    check_bit(mem_w, exp_flags[op][5], {s, " mem_w"});
    check_bit(wb_p, exp_flags[op][4], {s, " wb_p"});
    check_bit(wb_r, exp_flags[op][3], {s, " wb_r"});
    check_bit(is_jump, exp_flags[op][2], {s, " is_jump"});
    check_bit(jmp_reg, exp_flags[op][1], {s, " jmp_reg"});
    check_bit(link, exp_flags[op][0], {s, " link"});
  endtask

  task automatic test_reset;
    logic [3:0] id;
    for (int i = 0; i < 16; i++)
    begin
      id = 4'(i);
      apply_inst(reg_inst(6'h00, id, ~id, id));
      check_word(rx, gmodel[id], "reset rx");
      check_word(ry, gmodel[~id], "reset ry");
      check_bit(px, pmodel[id[1:0]], "reset px");
      check_bit(py, pmodel[~id[1:0]], "reset py");
      check_bit(pf_i | reg_mem, 1'b0, "nop pf_i or reg_mem");
      check_table(6'h00);
    end
  endtask

  task automatic test_table;
    for (int op = 0; op < 64; op++)
    begin
      apply_inst(reg_inst(6'(op), 4'd3, 4'd2, 4'd1));
      check_table(6'(op));
    end
  endtask

  task automatic test_reg_write;
    logic [31:0] r;
    logic [3:0] id;
    logic [xlen-1:0] d;
    for (int k = 0; k < 20; k++)
    begin
      r = $random(seed);
      id = r[3:0];
      d = $random(seed);
      @(negedge clk);
      r_we = 1'b1;
      r_wid = id;
      r_wdata = d;
      gmodel[id] = d;
      @(negedge clk);
      r_we = 1'b0;
      r_wdata = ~d; // must not land with we low
      inst = reg_inst(op_add, 4'd0, id, id);
      #1;
      check_word(rx, gmodel[id], "rx after write");
      check_word(ry, gmodel[id], "ry after write");
      apply_inst(inst);
      check_word(rx, gmodel[id], "rx after idle write");
    end
  endtask

  task automatic test_source_select;
    logic [31:0] r;
    for (int k = 0; k < 6; k++)
    begin
      r = $random(seed);
      apply_inst(reg_inst(op_st, r[3:0], r[7:4], r[11:8]));
      check_id(x_id, r[3:0], "st x_id");
      check_word(rx, gmodel[r[3:0]], "st rx");
      apply_inst(reg_inst(op_jmpr, r[3:0], r[7:4], r[11:8]));
      check_id(x_id, r[3:0], "jmpr x_id");
      apply_inst(reg_inst(op_add, r[3:0], r[7:4], r[11:8]));
      check_id(x_id, r[11:8], "add x_id");
      check_id(y_id, r[7:4], "add y_id");
      check_id(z_id, r[3:0], "add z_id");
      check_word(rx, gmodel[r[11:8]], "add rx");
      check_word(ry, gmodel[r[7:4]], "add ry");
    end
  endtask

  task automatic test_imm;
    logic [31:0] r;
    logic [22:0] f;
    logic [22:0] sign_bit;
    logic [5:0] op;
    logic [xlen-1:0] e;
    int w;
    for (int k = 0; k < 24; k++)
    begin
      r = $random(seed);
      op = (k % 3 == 0) ? op_ld : (k % 3 == 1) ? op_jmpi : op_ldi;
      w = (k % 3 == 0) ? 15 : (k % 3 == 1) ? 23 : 19;
      sign_bit = 23'(1) << (w - 1);
      f = ((k / 3) % 2 == 1) ? (r[22:0] | sign_bit) : (r[22:0] & ~sign_bit);
      @(negedge clk);
      pc_n = $random(seed);
      inst = imm_inst(op, f);
      #1;
      e = sext_ref(f, w);
      check_word(imm_s, e, $sformatf("imm_s op %h", op));
      check_word(jmp_target, pc_n + e, $sformatf("jmp_target op %h", op));
    end
  endtask

  task automatic test_pred;
    logic [31:0] r;
    inst_t i;
    for (int k = 0; k < 12; k++)
    begin
      r = $random(seed);
      @(negedge clk);
      p_we = 1'b1;
      p_wid = r[1:0];
      p_wdata = r[2];
      pmodel[r[1:0]] = r[2];
      @(negedge clk);
      p_we = 1'b0;
      i = reg_inst(op_andp, 4'd0, {2'b0, r[4:3]}, {2'b0, r[1:0]});
      i.reg_view.pset = 1'b1;
      i.reg_view.pid = r[1:0];
      inst = i;
      #1;
      check_bit(pval, pmodel[r[1:0]], "guarded pval");
      check_bit(px, pmodel[r[1:0]], "px after write");
      check_bit(py, pmodel[r[4:3]], "py after write");
      i.reg_view.pset = 1'b0;
      apply_inst(i);
      check_bit(pval, 1'b1, "unguarded pval");
    end
  endtask

  initial
  begin
    seed = 17658;
    rst = 1'b1;
    inst = '0;
    pc_n = '0;
    p_we = 1'b0;
    p_wid = '0;
    p_wdata = 1'b0;
    r_we = 1'b0;
    r_wid = '0;
    r_wdata = '0;
    for (int i = 0; i < 16; i++)
      gmodel[i] = xlen'(i);
    pmodel = '{1'b1, 1'b1, 1'b0, 1'b0};
    build_table();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_table();
    test_reg_write();
    test_source_select();
    test_imm();
    test_pred();
    $display("TESTS PASSED");
    $finish;
  end

endmodule
